// ==== Bender.yml ====
package:
  name: axi_lite_downsizer

sources:
  - include_dirs:
      - include
    files:
      - source/dw_pkg.sv
      - source/lite_spill_reg.sv
      - source/beat_counter.sv
      - source/addr_beat_gen.sv
      - source/w_lane_mux.sv
      - source/b_resp_merge.sv
      - source/r_beat_collect.sv
      - source/axi_lite_downsizer.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_axi_lite_downsizer.sv

// ==== bench/tb_axi_lite_downsizer.sv ====
`timescale 1ns/1ps

`include "dw_consts.svh"

// Testbench for the AXI4-Lite downsizer.
// A wide master drives the slave port, and a narrow slave model with its own memory
// answers on the master port with random stalls and random error responses.
// Every narrow and wide handshake is compared with values from the reference functions.
module tb_axi_lite_downsizer import dw_pkg::*; ();
  localparam int NUM_OPS   = 40;
  localparam int CYCLE_NS  = 40;
  localparam int MEM_WORDS = 32;

  logic clk_i;
  logic reset_i;
  // Slave side of the DUT, driven by the wide master tasks.
  addr_t        slv_aw_addr_i, slv_ar_addr_i;
  prot_t        slv_aw_prot_i, slv_ar_prot_i;
  wide_data_t   slv_w_data_i, slv_r_data_o;
  wide_strb_t   slv_w_strb_i;
  resp_t        slv_b_resp_o, slv_r_resp_o;
  logic         slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o;
  logic         slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic         slv_r_valid_o, slv_r_ready_i;
  // Master side of the DUT, driven by the narrow slave model.
  addr_t        mst_aw_addr_o, mst_ar_addr_o;
  prot_t        mst_aw_prot_o, mst_ar_prot_o;
  narrow_data_t mst_w_data_o, mst_r_data_i;
  narrow_strb_t mst_w_strb_o;
  resp_t        mst_b_resp_i, mst_r_resp_i;
  logic         mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i;
  logic         mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic         mst_r_valid_i, mst_r_ready_o;

  // Expected narrow beats and wide read data, in issue order.
  addr_chan_t   exp_aw_q[$];
  addr_chan_t   exp_ar_q[$];
  narrow_data_t exp_wd_q[$];
  narrow_strb_t exp_ws_q[$];
  wide_data_t   exp_r_q[$];
  narrow_data_t exp_mem[MEM_WORDS];
  // State of the narrow slave model.
  narrow_data_t model_mem[MEM_WORDS];
  addr_t        aw_seen_q[$];
  addr_t        ar_seen_q[$];
  narrow_data_t wd_seen_q[$];
  narrow_strb_t ws_seen_q[$];
  resp_t        b_pend_q[$];
  resp_t        b_log_q[$];
  resp_t        r_log_q[$];
  logic         b_taken;
  logic         r_taken;
  // Handshake counters for the final balance check.
  int           num_writes, num_reads, wide_b, wide_r;
  int           narrow_aw, narrow_w, narrow_b, narrow_ar, narrow_r;

  tb_clock_gen #(.PERIOD_NS(CYCLE_NS), .RESET_CYCLES(16)) u_clock_gen (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  axi_lite_downsizer uut (.*);

  // Narrow address of beat n. The lane bits hold n and the byte offset is zero.
  function automatic addr_t ref_addr(addr_t wide_addr, int n);
    addr_t lane_mask;
    lane_mask = addr_t'(`DW_FACTOR * `DW_NARROW_STRB_WIDTH - 1);
    ref_addr  = (wide_addr & ~lane_mask) | addr_t'(n * `DW_NARROW_STRB_WIDTH);
  endfunction

  // Data and strobe slices of beat n, lowest slice first.
  function automatic narrow_data_t ref_data(wide_data_t d, int n);
    ref_data = narrow_data_t'(d >> (n * `DW_NARROW_DATA_WIDTH));
  endfunction

  function automatic narrow_strb_t ref_strb(wide_strb_t s, int n);
    ref_strb = narrow_strb_t'(s >> (n * `DW_NARROW_STRB_WIDTH));
  endfunction

  // The small narrow memory wraps, so many addresses share a word.
  function automatic int word_index(addr_t a);
    word_index = int'((a >> `DW_SEL_OFFSET) % MEM_WORDS);
  endfunction

  // Power-up content that differs in every word.
  function automatic narrow_data_t fill_word(int idx);
    fill_word = 32'h5a3c_0000 ^ narrow_data_t'(idx * 32'h0001_0203);
  endfunction

  // Describes the failure, then ends the run.
  task automatic abort_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at %0t.", $time);
  endtask

  task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Each wide request waits a random number of cycles before it is offered.
  task automatic send_aw(addr_t a, prot_t p);
    repeat ($urandom_range(1, 3)) @(negedge clk_i);
    slv_aw_addr_i  = a;
    slv_aw_prot_i  = p;
    slv_aw_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!slv_aw_ready_o);
    @(negedge clk_i);
    slv_aw_valid_i = 1'b0;
  endtask

  task automatic send_w(wide_data_t d, wide_strb_t s);
    repeat ($urandom_range(1, 3)) @(negedge clk_i);
    slv_w_data_i  = d;
    slv_w_strb_i  = s;
    slv_w_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!slv_w_ready_o);
    @(negedge clk_i);
    slv_w_valid_i = 1'b0;
  endtask

  task automatic send_ar(addr_t a, prot_t p);
    repeat ($urandom_range(1, 3)) @(negedge clk_i);
    slv_ar_addr_i  = a;
    slv_ar_prot_i  = p;
    slv_ar_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!slv_ar_ready_o);
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
  endtask

  // Compare process.
  // Handshakes are judged on the values that were stable before the rising edge.
  always @(posedge clk_i) begin : compare
    addr_chan_t ac;
    resp_t      merged;
    if (!reset_i) begin
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (exp_aw_q.size() == 0) begin
          abort_run("A narrow AW beat appeared that no wide write asked for.");
        end
        ac = exp_aw_q.pop_front();
        compare_value("mst_aw_addr_o", mst_aw_addr_o, ac.addr);
        compare_value("mst_aw_prot_o", mst_aw_prot_o, ac.prot);
        aw_seen_q.push_back(mst_aw_addr_o);
        narrow_aw++;
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (exp_wd_q.size() == 0) begin
          abort_run("A narrow W beat appeared that no wide write asked for.");
        end
        compare_value("mst_w_data_o", mst_w_data_o, exp_wd_q.pop_front());
        compare_value("mst_w_strb_o", mst_w_strb_o, exp_ws_q.pop_front());
        wd_seen_q.push_back(mst_w_data_o);
        ws_seen_q.push_back(mst_w_strb_o);
        narrow_w++;
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (exp_ar_q.size() == 0) begin
          abort_run("A narrow AR beat appeared that no wide read asked for.");
        end
        ac = exp_ar_q.pop_front();
        compare_value("mst_ar_addr_o", mst_ar_addr_o, ac.addr);
        compare_value("mst_ar_prot_o", mst_ar_prot_o, ac.prot);
        ar_seen_q.push_back(mst_ar_addr_o);
        narrow_ar++;
      end
      if (mst_b_valid_i && mst_b_ready_o) begin
        b_taken = 1'b1;
        narrow_b++;
      end
      if (mst_r_valid_i && mst_r_ready_o) begin
        r_taken = 1'b1;
        narrow_r++;
      end
      // A wide response is the OR of the narrow responses that the model sent for it.
      if (slv_b_valid_o && slv_b_ready_i) begin
        if (b_log_q.size() < `DW_FACTOR) begin
          abort_run("A wide B arrived before all of its narrow responses were sent.");
        end
        merged = RESP_OKAY;
        repeat (`DW_FACTOR) merged = merged | b_log_q.pop_front();
        compare_value("slv_b_resp_o", slv_b_resp_o, merged);
        wide_b++;
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        if (r_log_q.size() < `DW_FACTOR || exp_r_q.size() == 0) begin
          abort_run("A wide R arrived that does not match any complete read.");
        end
        merged = RESP_OKAY;
        repeat (`DW_FACTOR) merged = merged | r_log_q.pop_front();
        compare_value("slv_r_resp_o", slv_r_resp_o, merged);
        compare_value("slv_r_data_o", slv_r_data_o, exp_r_q.pop_front());
        wide_r++;
      end
    end
  end

  // Narrow slave model, and the ready inputs of both ports, on the falling edge.
  always @(negedge clk_i) begin : slave_model
    int idx;
    if (!reset_i) begin
      mst_aw_ready_i = ($urandom_range(0, 3) != 0);
      mst_w_ready_i  = ($urandom_range(0, 3) != 0);
      mst_ar_ready_i = ($urandom_range(0, 3) != 0);
      slv_b_ready_i  = ($urandom_range(0, 3) != 0);
      slv_r_ready_i  = ($urandom_range(0, 3) != 0);
      // A narrow write lands once both its address and its data have arrived.
      if (aw_seen_q.size() > 0 && wd_seen_q.size() > 0) begin
        idx = word_index(aw_seen_q.pop_front());
        for (int b = 0; b < `DW_NARROW_STRB_WIDTH; b++) begin
          if (ws_seen_q[0][b]) begin
            model_mem[idx][8*b +: 8] = wd_seen_q[0][8*b +: 8];
          end
        end
        wd_seen_q.delete(0);
        ws_seen_q.delete(0);
        b_pend_q.push_back(($urandom_range(0, 3) == 0) ? RESP_SLVERR : RESP_OKAY);
      end
      // Retire the beat taken at the last rising edge before offering another.
      if (b_taken) begin
        mst_b_valid_i = 1'b0;
        b_taken       = 1'b0;
      end
      if (!mst_b_valid_i && b_pend_q.size() > 0 && $urandom_range(0, 1) == 1) begin
        mst_b_resp_i  = b_pend_q.pop_front();
        mst_b_valid_i = 1'b1;
        b_log_q.push_back(mst_b_resp_i);
      end
      if (r_taken) begin
        mst_r_valid_i = 1'b0;
        r_taken       = 1'b0;
      end
      if (!mst_r_valid_i && ar_seen_q.size() > 0 && $urandom_range(0, 1) == 1) begin
        mst_r_data_i  = model_mem[word_index(ar_seen_q.pop_front())];
        mst_r_resp_i  = ($urandom_range(0, 3) == 0) ? RESP_SLVERR : RESP_OKAY;
        mst_r_valid_i = 1'b1;
        r_log_q.push_back(mst_r_resp_i);
      end
    end
  end

  // Stimulus. Each operation waits for its wide response before the next one starts.
  initial begin : stimulus
    addr_t      a;
    prot_t      p;
    wide_data_t d;
    wide_strb_t s;
    wide_data_t rd;
    int         idx;
    slv_aw_addr_i  = '0;
    slv_aw_prot_i  = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    slv_ar_addr_i  = '0;
    slv_ar_prot_i  = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_resp_i   = RESP_OKAY;
    mst_b_valid_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = RESP_OKAY;
    mst_r_valid_i  = 1'b0;
    b_taken        = 1'b0;
    r_taken        = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      exp_mem[i]   = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    void'($urandom(32'h35c1));
    wait (reset_i === 1'b1);
    wait (reset_i === 1'b0);
    @(negedge clk_i);
    // Nothing may be offered on any port straight after reset.
    compare_value("mst_aw_valid_o", mst_aw_valid_o, 1'b0);
    compare_value("mst_w_valid_o", mst_w_valid_o, 1'b0);
    compare_value("mst_ar_valid_o", mst_ar_valid_o, 1'b0);
    compare_value("slv_b_valid_o", slv_b_valid_o, 1'b0);
    compare_value("slv_r_valid_o", slv_r_valid_o, 1'b0);
    for (int op = 0; op < NUM_OPS; op++) begin
      a = $urandom;
      p = prot_t'($urandom);
      if (op < 2 || $urandom_range(0, 1) == 0) begin
        // The first two writes use half-word strobes, upper lane first, then lower.
        d = {$urandom, $urandom};
        s = (op == 0) ? 8'hF0 : (op == 1) ? 8'h0F : wide_strb_t'($urandom);
        for (int n = 0; n < `DW_FACTOR; n++) begin
          exp_aw_q.push_back(addr_chan_t'{ref_addr(a, n), p});
          exp_wd_q.push_back(ref_data(d, n));
          exp_ws_q.push_back(ref_strb(s, n));
          idx = word_index(ref_addr(a, n));
          for (int b = 0; b < `DW_NARROW_STRB_WIDTH; b++) begin
            if (s[n*`DW_NARROW_STRB_WIDTH + b]) begin
              exp_mem[idx][8*b +: 8] = d[8*(n*`DW_NARROW_STRB_WIDTH + b) +: 8];
            end
          end
        end
        num_writes++;
        fork
          send_aw(a, p);
          send_w(d, s);
        join
        wait (wide_b == num_writes);
      end else begin
        // Read data is what the earlier writes left in memory.
        rd = '0;
        for (int n = 0; n < `DW_FACTOR; n++) begin
          exp_ar_q.push_back(addr_chan_t'{ref_addr(a, n), p});
          rd[n*`DW_NARROW_DATA_WIDTH +: `DW_NARROW_DATA_WIDTH] = exp_mem[word_index(ref_addr(a, n))];
        end
        exp_r_q.push_back(rd);
        num_reads++;
        send_ar(a, p);
        wait (wide_r == num_reads);
      end
    end
    @(negedge clk_i);
    // Every wide transfer must have turned into exactly DW_FACTOR narrow transfers.
    compare_value("narrow AW count", narrow_aw, `DW_FACTOR * num_writes);
    compare_value("narrow W count", narrow_w, `DW_FACTOR * num_writes);
    compare_value("narrow B count", narrow_b, `DW_FACTOR * num_writes);
    compare_value("narrow AR count", narrow_ar, `DW_FACTOR * num_reads);
    compare_value("narrow R count", narrow_r, `DW_FACTOR * num_reads);
    compare_value("open expected beats", exp_aw_q.size() + exp_wd_q.size() + exp_ar_q.size(), 0);
    $display(">>> PASS");
    $finish;
  end

  // Watchdog with 200 cycles for each operation plus the reset phase.
  initial begin : watchdog
    #((NUM_OPS * 200 + 16) * CYCLE_NS);
    abort_run($sformatf("Timeout: the run did not finish within %0d cycles.",
                        NUM_OPS * 200 + 16));
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Clock and reset source for the downsizer testbench.
// The reset is synchronous and active high, and it is released on a falling edge.
module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic reset_o
);
  // Free-running clock with a 50 percent duty cycle.
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset covers the first rising edges, then drops away from the sampling edge.
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// ==== include/dw_consts.svh ====
`ifndef DW_CONSTS_SVH
`define DW_CONSTS_SVH

// Address width shared by both ports.
`define DW_ADDR_WIDTH 32

// Data width of the wide slave port and of the narrow master port.
`define DW_WIDE_DATA_WIDTH 64
`define DW_NARROW_DATA_WIDTH 32

// One strobe bit per data byte.
`define DW_WIDE_STRB_WIDTH (`DW_WIDE_DATA_WIDTH / 8)
`define DW_NARROW_STRB_WIDTH (`DW_NARROW_DATA_WIDTH / 8)

// Number of narrow beats per wide beat, and the address bits that pick a beat.
`define DW_FACTOR (`DW_WIDE_DATA_WIDTH / `DW_NARROW_DATA_WIDTH)
`define DW_SEL_WIDTH ($clog2(`DW_FACTOR))
`define DW_SEL_OFFSET ($clog2(`DW_NARROW_STRB_WIDTH))

`endif

// ==== source/addr_beat_gen.sv ====
`timescale 1ns/1ps

`include "dw_consts.svh"

// Splits one spilled wide address into DW_FACTOR narrow address beats.
// Used for both AW and AR, since the two channels behave the same here.
module addr_beat_gen import dw_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  addr_chan_t in_chan_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output addr_t      out_addr_o,
  output prot_t      out_prot_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);
  sel_t sel;
  logic last;
  logic beat_done;

  // One narrow beat completes per master-side handshake.
  assign beat_done = out_valid_o & out_ready_i;

  beat_counter u_beat_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .step_i  (beat_done),
    .sel_o   (sel),
    .last_o  (last)
  );

  // Each narrow address is aligned to the narrow bus.
  // The lane-select bits carry the beat index, the byte offset below them is cleared.
  always_comb begin
    out_addr_o = in_chan_i.addr;
    out_addr_o[`DW_SEL_OFFSET +: `DW_SEL_WIDTH] = sel;
    out_addr_o[`DW_SEL_OFFSET-1:0] = '0;
  end

  // Protection bits are copied to every narrow beat unchanged.
  assign out_prot_o = in_chan_i.prot;

  // The spilled item stays put until its last narrow beat is accepted.
  assign out_valid_o = in_valid_i;
  assign in_ready_o  = out_ready_i & last;

endmodule

// ==== source/axi_lite_downsizer.sv ====
`timescale 1ns/1ps

// AXI4-Lite data width downsizer.
// Every wide transfer on the slave port becomes DW_FACTOR narrow transfers on the master
// port. The AW, W and B paths run independently of each other, as do AR and R.
module axi_lite_downsizer import dw_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  // Slave port, wide data.
  input  addr_t        slv_aw_addr_i,
  input  prot_t        slv_aw_prot_i,
  input  logic         slv_aw_valid_i,
  output logic         slv_aw_ready_o,
  input  wide_data_t   slv_w_data_i,
  input  wide_strb_t   slv_w_strb_i,
  input  logic         slv_w_valid_i,
  output logic         slv_w_ready_o,
  output resp_t        slv_b_resp_o,
  output logic         slv_b_valid_o,
  input  logic         slv_b_ready_i,
  input  addr_t        slv_ar_addr_i,
  input  prot_t        slv_ar_prot_i,
  input  logic         slv_ar_valid_i,
  output logic         slv_ar_ready_o,
  output wide_data_t   slv_r_data_o,
  output resp_t        slv_r_resp_o,
  output logic         slv_r_valid_o,
  input  logic         slv_r_ready_i,
  // Master port, narrow data.
  output addr_t        mst_aw_addr_o,
  output prot_t        mst_aw_prot_o,
  output logic         mst_aw_valid_o,
  input  logic         mst_aw_ready_i,
  output narrow_data_t mst_w_data_o,
  output narrow_strb_t mst_w_strb_o,
  output logic         mst_w_valid_o,
  input  logic         mst_w_ready_i,
  input  resp_t        mst_b_resp_i,
  input  logic         mst_b_valid_i,
  output logic         mst_b_ready_o,
  output addr_t        mst_ar_addr_o,
  output prot_t        mst_ar_prot_o,
  output logic         mst_ar_valid_o,
  input  logic         mst_ar_ready_i,
  input  narrow_data_t mst_r_data_i,
  input  resp_t        mst_r_resp_i,
  input  logic         mst_r_valid_i,
  output logic         mst_r_ready_o
);
  addr_chan_t   aw_in;
  addr_chan_t   aw_spill;
  logic         aw_spill_valid;
  logic         aw_spill_ready;
  wide_w_chan_t w_in;
  wide_w_chan_t w_spill;
  logic         w_spill_valid;
  logic         w_spill_ready;
  addr_chan_t   ar_in;
  addr_chan_t   ar_spill;
  logic         ar_spill_valid;
  logic         ar_spill_ready;

  // Slave-side request fields are bundled so that one spill register holds each channel.
  assign aw_in = '{addr: slv_aw_addr_i, prot: slv_aw_prot_i};
  assign w_in  = '{data: slv_w_data_i, strb: slv_w_strb_i};
  assign ar_in = '{addr: slv_ar_addr_i, prot: slv_ar_prot_i};

  // Write address path.
  lite_spill_reg #(.payload_t(addr_chan_t)) u_aw_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_aw_valid_i),
    .ready_o (slv_aw_ready_o),
    .data_i  (aw_in),
    .valid_o (aw_spill_valid),
    .ready_i (aw_spill_ready),
    .data_o  (aw_spill)
  );

  addr_beat_gen u_aw_gen (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_chan_i   (aw_spill),
    .in_valid_i  (aw_spill_valid),
    .in_ready_o  (aw_spill_ready),
    .out_addr_o  (mst_aw_addr_o),
    .out_prot_o  (mst_aw_prot_o),
    .out_valid_o (mst_aw_valid_o),
    .out_ready_i (mst_aw_ready_i)
  );

  // Write data path.
  lite_spill_reg #(.payload_t(wide_w_chan_t)) u_w_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_w_valid_i),
    .ready_o (slv_w_ready_o),
    .data_i  (w_in),
    .valid_o (w_spill_valid),
    .ready_i (w_spill_ready),
    .data_o  (w_spill)
  );

  w_lane_mux u_w_mux (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_chan_i   (w_spill),
    .in_valid_i  (w_spill_valid),
    .in_ready_o  (w_spill_ready),
    .out_data_o  (mst_w_data_o),
    .out_strb_o  (mst_w_strb_o),
    .out_valid_o (mst_w_valid_o),
    .out_ready_i (mst_w_ready_i)
  );

  // Write response path.
  b_resp_merge u_b_merge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mst_resp_i  (mst_b_resp_i),
    .mst_valid_i (mst_b_valid_i),
    .mst_ready_o (mst_b_ready_o),
    .slv_resp_o  (slv_b_resp_o),
    .slv_valid_o (slv_b_valid_o),
    .slv_ready_i (slv_b_ready_i)
  );

  // Read address path.
  lite_spill_reg #(.payload_t(addr_chan_t)) u_ar_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_ar_valid_i),
    .ready_o (slv_ar_ready_o),
    .data_i  (ar_in),
    .valid_o (ar_spill_valid),
    .ready_i (ar_spill_ready),
    .data_o  (ar_spill)
  );

  addr_beat_gen u_ar_gen (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_chan_i   (ar_spill),
    .in_valid_i  (ar_spill_valid),
    .in_ready_o  (ar_spill_ready),
    .out_addr_o  (mst_ar_addr_o),
    .out_prot_o  (mst_ar_prot_o),
    .out_valid_o (mst_ar_valid_o),
    .out_ready_i (mst_ar_ready_i)
  );

  // Read data path.
  r_beat_collect u_r_collect (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mst_data_i  (mst_r_data_i),
    .mst_resp_i  (mst_r_resp_i),
    .mst_valid_i (mst_r_valid_i),
    .mst_ready_o (mst_r_ready_o),
    .slv_data_o  (slv_r_data_o),
    .slv_resp_o  (slv_r_resp_o),
    .slv_valid_o (slv_r_valid_o),
    .slv_ready_i (slv_r_ready_i)
  );

endmodule

// ==== source/b_resp_merge.sv ====
`timescale 1ns/1ps

// Collects the narrow B responses of one wide write into one wide B.
// Only the last narrow B is shown to the slave port, the ones before it are absorbed.
module b_resp_merge import dw_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  resp_t mst_resp_i,
  input  logic  mst_valid_i,
  output logic  mst_ready_o,
  output resp_t slv_resp_o,
  output logic  slv_valid_o,
  input  logic  slv_ready_i
);
  logic  last;
  logic  resp_take;
  resp_t resp_q;

  // Earlier beats are always taken. The last one waits for the slave port.
  assign mst_ready_o = last ? slv_ready_i : 1'b1;
  assign resp_take   = mst_valid_i & mst_ready_o;

  // Only the last-beat flag matters here, the beat index itself is not needed.
  beat_counter u_beat_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .step_i  (resp_take),
    .sel_o   (),
    .last_o  (last)
  );

  // The wide B goes out on the same cycle as the last narrow B.
  assign slv_valid_o = mst_valid_i & last;
  assign slv_resp_o  = resp_q | mst_resp_i;

  // Accumulated response of the beats seen so far.
  // Clears to OKAY once the merged response has been handed on.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_q <= RESP_OKAY;
    end else if (resp_take) begin
      if (last) begin
        resp_q <= RESP_OKAY;
      end else begin
        resp_q <= resp_q | mst_resp_i;
      end
    end
  end

endmodule

// ==== source/beat_counter.sv ====
`timescale 1ns/1ps

`include "dw_consts.svh"

// Narrow beat index within one wide beat.
// Every channel path uses one of these to walk through the lanes.
module beat_counter import dw_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic step_i,
  output sel_t sel_o,
  output logic last_o
);
  sel_t sel_q;

  // The index sits on the last lane while the final narrow beat is pending.
  assign last_o = (sel_q == sel_t'(`DW_FACTOR - 1));
  assign sel_o  = sel_q;

  // Advance once per handshake and wrap back to lane zero after the last one.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q <= '0;
    end else if (step_i) begin
      if (last_o) begin
        sel_q <= '0;
      end else begin
        sel_q <= sel_q + sel_t'(1);
      end
    end
  end

endmodule

// ==== source/dw_pkg.sv ====
`include "dw_consts.svh"

// Types shared by the downsizer RTL and its testbench.
package dw_pkg;

  typedef logic [`DW_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DW_WIDE_DATA_WIDTH-1:0] wide_data_t;
  typedef logic [`DW_WIDE_STRB_WIDTH-1:0] wide_strb_t;
  typedef logic [`DW_NARROW_DATA_WIDTH-1:0] narrow_data_t;
  typedef logic [`DW_NARROW_STRB_WIDTH-1:0] narrow_strb_t;

  // Index of the narrow beat within one wide beat.
  typedef logic [`DW_SEL_WIDTH-1:0] sel_t;

  // AXI response codes. Merging is a bitwise OR, so an error on any beat wins.
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef logic [2:0] prot_t;

  // Payloads that are held in the input spill registers.
  typedef struct packed {addr_t addr; prot_t prot;} addr_chan_t;
  typedef struct packed {wide_data_t data; wide_strb_t strb;} wide_w_chan_t;

endpackage

// ==== source/lite_spill_reg.sv ====
`timescale 1ns/1ps

// Two-entry spill register for a valid/ready channel.
// Slot A takes every new item. When the consumer stalls, the item in A moves on to
// slot B, so A can accept one more beat. The upstream ready therefore depends only on
// local state and never on the downstream ready.
module lite_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);
  payload_t a_data_q;
  logic     a_full_q;
  logic     a_fill;
  logic     a_drain;
  payload_t b_data_q;
  logic     b_full_q;
  logic     b_fill;
  logic     b_drain;

  // Slot A loads on every upstream handshake.
  // It is emptied whenever slot B is free, either to the consumer or into B.
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill | (a_full_q & ~a_drain);
    end
  end

  // Slot B catches the item from A when the consumer is not ready.
  // It always holds the older item, so it is presented first.
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_full_q <= 1'b0;
    end else begin
      b_full_q <= b_fill | (b_full_q & ~b_drain);
    end
  end

  // Ready drops only when both slots are occupied.
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

// ==== source/r_beat_collect.sv ====
`timescale 1ns/1ps

`include "dw_consts.svh"

// Gathers DW_FACTOR narrow R beats into one wide R beat.
// The first DW_FACTOR-1 beats are stored; the last one is passed straight through,
// so it needs no register of its own.
module r_beat_collect import dw_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  narrow_data_t mst_data_i,
  input  resp_t        mst_resp_i,
  input  logic         mst_valid_i,
  output logic         mst_ready_o,
  output wide_data_t   slv_data_o,
  output resp_t        slv_resp_o,
  output logic         slv_valid_o,
  input  logic         slv_ready_i
);
  sel_t         sel;
  logic         last;
  logic         beat_take;
  narrow_data_t data_q [`DW_FACTOR-1];
  resp_t        resp_q;

  // Stored beats are always accepted. The last beat waits for the slave port.
  assign mst_ready_o = last ? slv_ready_i : 1'b1;
  assign beat_take   = mst_valid_i & mst_ready_o;

  beat_counter u_beat_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .step_i  (beat_take),
    .sel_o   (sel),
    .last_o  (last)
  );

  // Each stored beat lands in the register of its lane.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `DW_FACTOR - 1; i++) begin
      if (beat_take && (sel == sel_t'(i))) begin
        data_q[i] <= mst_data_i;
      end
    end
  end

  // Response OR of the stored beats.
  // Back to OKAY after the wide beat has been delivered.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_q <= RESP_OKAY;
    end else if (beat_take) begin
      if (last) begin
        resp_q <= RESP_OKAY;
      end else begin
        resp_q <= resp_q | mst_resp_i;
      end
    end
  end

  // Stored lanes fill the wide word from the bottom up.
  // The live beat forms the top lane.
  always_comb begin
    for (int i = 0; i < `DW_FACTOR - 1; i++) begin
      slv_data_o[i*`DW_NARROW_DATA_WIDTH +: `DW_NARROW_DATA_WIDTH] = data_q[i];
    end
    slv_data_o[(`DW_FACTOR-1)*`DW_NARROW_DATA_WIDTH +: `DW_NARROW_DATA_WIDTH] = mst_data_i;
  end

  assign slv_resp_o  = resp_q | mst_resp_i;
  assign slv_valid_o = mst_valid_i & last;

endmodule

// ==== source/w_lane_mux.sv ====
`timescale 1ns/1ps

`include "dw_consts.svh"

// Issues one spilled wide W beat as DW_FACTOR narrow data and strobe slices.
// The lowest slice goes out first, matching the lane order of the addresses.
module w_lane_mux import dw_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  wide_w_chan_t in_chan_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,
  output narrow_data_t out_data_o,
  output narrow_strb_t out_strb_o,
  output logic         out_valid_o,
  input  logic         out_ready_i
);
  sel_t sel;
  logic last;
  logic slice_done;

  // The W path counts on its own, it does not look at the AW path.
  assign slice_done = out_valid_o & out_ready_i;

  beat_counter u_beat_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .step_i  (slice_done),
    .sel_o   (sel),
    .last_o  (last)
  );

  // Pick the lane that the beat index points to.
  // Strobes are sliced the same way, so unwritten lanes keep a zero strobe.
  assign out_data_o = in_chan_i.data[sel*`DW_NARROW_DATA_WIDTH +: `DW_NARROW_DATA_WIDTH];
  assign out_strb_o = in_chan_i.strb[sel*`DW_NARROW_STRB_WIDTH +: `DW_NARROW_STRB_WIDTH];

  // A wide beat with no strobes set still produces all of its narrow beats.
  assign out_valid_o = in_valid_i;

  // Release the spill entry only with the handshake of the final slice.
  assign in_ready_o = out_ready_i & last;

endmodule

// ==== src.f ====
+incdir+include
source/dw_pkg.sv
source/lite_spill_reg.sv
source/beat_counter.sv
source/addr_beat_gen.sv
source/w_lane_mux.sv
source/b_resp_merge.sv
source/r_beat_collect.sv
source/axi_lite_downsizer.sv
bench/tb_clock_gen.sv
bench/tb_axi_lite_downsizer.sv
